/* mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    // segment start addresses, only bits 31:29 are decoded
    localparam logic [31:0] KSEG0_BASE = 32'h8000_0000;  // unmapped, cacheable
    localparam logic [31:0] KSEG1_BASE = 32'hA000_0000;  // unmapped, uncached
    localparam logic [31:0] KSEG2_BASE = 32'hC000_0000;  // mapped kernel

    // kuseg is everything below KSEG0_BASE
    // kseg3 is everything from KSEG2_BASE + 512 MiB up
    typedef enum logic [2:0] {
        SEG_KUSEG = 3'd0,
        SEG_KSEG0 = 3'd1,
        SEG_KSEG1 = 3'd2,
        SEG_KSEG2 = 3'd3,
        SEG_KSEG3 = 3'd4
    } seg_e;

    // entry-lo C field value for an uncached page
    localparam logic [2:0] CACHE_UNCACHED = 3'd2;

endpackage

`default_nettype wire

/* tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

    localparam int VPN2_W = 19;  // va bits 31:13
    localparam int ASID_W = 8;
    localparam int PFN_W  = 20;  // pa bits 31:12
    localparam int CFLD_W = 3;

    // one even/odd pair of 4 KiB pages
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        // even page, va bit 12 clear
        logic [PFN_W-1:0]  pfn0;
        logic [CFLD_W-1:0] c0;
        logic              d0;
        logic              v0;
        // odd page, va bit 12 set
        logic [PFN_W-1:0]  pfn1;
        logic [CFLD_W-1:0] c1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

endpackage

`default_nettype wire

/* memory_map.sv */
`default_nettype none

module memory_map #(
    parameter bit ENABLE_TLB = 1'b1
) (
    input  logic [31:0] addr_i,
    input  logic        en_i,
    input  logic        user_mode_i,
    input  logic        kseg0_uncached_i,
    output logic [31:0] addr_o,
    output logic        uncached_o,
    output logic        use_tlb_o,
    output logic        except_user_o
);
    import mmu_pkg::*;

    seg_e seg;
    logic mapped;

    always_comb begin
        if (!addr_i[31]) begin
            seg = SEG_KUSEG;
        end else if (addr_i[31:29] == KSEG0_BASE[31:29]) begin
            seg = SEG_KSEG0;
        end else if (addr_i[31:29] == KSEG1_BASE[31:29]) begin
            seg = SEG_KSEG1;
        end else if (addr_i[31:29] == KSEG2_BASE[31:29]) begin
            seg = SEG_KSEG2;
        end else begin
            seg = SEG_KSEG3;
        end
    end

    // fixed translation, mapped segments pass through cached
    always_comb begin
        mapped     = 1'b0;
        uncached_o = 1'b0;
        addr_o     = addr_i;
        case (seg)
            SEG_KSEG0: begin
                addr_o     = {3'b000, addr_i[28:0]};
                uncached_o = kseg0_uncached_i;  // config K0 override
            end
            SEG_KSEG1: begin
                addr_o     = {3'b000, addr_i[28:0]};
                uncached_o = 1'b1;
            end
            default: begin
                mapped = 1'b1;  // kuseg, kseg2, kseg3
            end
        endcase
    end

    assign use_tlb_o = ENABLE_TLB & mapped;

    // any kernel address from user mode
    assign except_user_o = en_i & user_mode_i & addr_i[31];

endmodule

`default_nettype wire

/* tlb.sv */
`default_nettype none

module tlb #(
    parameter  int TLB_ENTRIES = 16,
    localparam int IDX_W       = $clog2(TLB_ENTRIES)
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic [tlb_pkg::ASID_W-1:0] asid_i,

    input  logic [31:0]                inst_addr_i,
    output logic [31:0]                inst_addr_o,
    output logic                       inst_uncached_o,
    output logic                       inst_miss_o,
    output logic                       inst_valid_o,

    input  logic [31:0]                data_addr_i,
    output logic [31:0]                data_addr_o,
    output logic                       data_uncached_o,
    output logic                       data_miss_o,
    output logic                       data_valid_o,
    output logic                       data_dirty_o,

    input  logic                       tlb_we_i,
    input  logic [IDX_W-1:0]           tlb_index_i,
    input  logic [tlb_pkg::VPN2_W-1:0] entry_vpn2_i,
    input  logic [tlb_pkg::ASID_W-1:0] entry_asid_i,
    input  logic                       entry_g_i,
    input  logic [tlb_pkg::PFN_W-1:0]  lo0_pfn_i,
    input  logic [tlb_pkg::CFLD_W-1:0] lo0_c_i,
    input  logic                       lo0_d_i,
    input  logic                       lo0_v_i,
    input  logic [tlb_pkg::PFN_W-1:0]  lo1_pfn_i,
    input  logic [tlb_pkg::CFLD_W-1:0] lo1_c_i,
    input  logic                       lo1_d_i,
    input  logic                       lo1_v_i,

    input  logic                       tlb_probe_i,
    output logic [31:0]                tlb_probe_res_o
);
    import mmu_pkg::*;
    import tlb_pkg::*;

    typedef struct packed {
        logic [PFN_W-1:0]  pfn;
        logic [CFLD_W-1:0] c;
        logic              d;
        logic              v;
    } page_t;

    tlb_entry_t             entries_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] filled_q;  // never-written entries cannot match
    tlb_entry_t             wr_entry;

    logic                   inst_hit;
    logic                   data_hit;
    logic                   probe_hit;
    logic [IDX_W-1:0]       inst_idx;
    logic [IDX_W-1:0]       data_idx;
    logic [IDX_W-1:0]       probe_idx;
    page_t                  inst_pg;
    page_t                  data_pg;

    function automatic logic match(input tlb_entry_t e, input logic filled,
                                   input logic [VPN2_W-1:0] vpn2,
                                   input logic [ASID_W-1:0] asid);
        return filled && (e.vpn2 == vpn2) && (e.g || (e.asid == asid));
    endfunction

    function automatic page_t pick(input tlb_entry_t e, input logic odd);
        page_t p;
        if (odd) begin
            p = '{pfn: e.pfn1, c: e.c1, d: e.d1, v: e.v1};
        end else begin
            p = '{pfn: e.pfn0, c: e.c0, d: e.d0, v: e.v0};
        end
        return p;
    endfunction

    // fully associative search, descending so the lowest index wins
    always_comb begin
        inst_hit  = 1'b0;
        inst_idx  = '0;
        data_hit  = 1'b0;
        data_idx  = '0;
        probe_hit = 1'b0;
        probe_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match(entries_q[i], filled_q[i], inst_addr_i[31:13], asid_i)) begin
                inst_hit = 1'b1;
                inst_idx = IDX_W'(i);
            end
            if (match(entries_q[i], filled_q[i], data_addr_i[31:13], asid_i)) begin
                data_hit = 1'b1;
                data_idx = IDX_W'(i);
            end
            if (match(entries_q[i], filled_q[i], entry_vpn2_i, entry_asid_i)) begin
                probe_hit = 1'b1;
                probe_idx = IDX_W'(i);
            end
        end
    end

    assign inst_pg = pick(entries_q[inst_idx], inst_addr_i[12]);
    assign data_pg = pick(entries_q[data_idx], data_addr_i[12]);

    // on a miss the va goes out unchanged
    assign inst_miss_o     = ~inst_hit;
    assign inst_valid_o    = inst_hit & inst_pg.v;
    assign inst_uncached_o = inst_hit & (inst_pg.c == CACHE_UNCACHED);
    assign inst_addr_o     = inst_hit ? {inst_pg.pfn, inst_addr_i[11:0]} : inst_addr_i;

    assign data_miss_o     = ~data_hit;
    assign data_valid_o    = data_hit & data_pg.v;
    assign data_uncached_o = data_hit & (data_pg.c == CACHE_UNCACHED);
    assign data_dirty_o    = data_hit & data_pg.d;
    assign data_addr_o     = data_hit ? {data_pg.pfn, data_addr_i[11:0]} : data_addr_i;

    always_comb begin
        wr_entry      = '0;
        wr_entry.vpn2 = entry_vpn2_i;
        wr_entry.asid = entry_asid_i;
        wr_entry.g    = entry_g_i;
        wr_entry.pfn0 = lo0_pfn_i;
        wr_entry.c0   = lo0_c_i;
        wr_entry.d0   = lo0_d_i;
        wr_entry.v0   = lo0_v_i;
        wr_entry.pfn1 = lo1_pfn_i;
        wr_entry.c1   = lo1_c_i;
        wr_entry.d1   = lo1_d_i;
        wr_entry.v1   = lo1_v_i;
    end

    // indexed write, visible to lookups next cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            entries_q <= '{default: '0};
            filled_q  <= '0;
        end else if (tlb_we_i) begin
            entries_q[tlb_index_i] <= wr_entry;
            filled_q[tlb_index_i]  <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tlb_probe_res_o <= 32'h8000_0000;
        end else if (tlb_probe_i) begin
            tlb_probe_res_o <= {~probe_hit, {(31 - IDX_W){1'b0}}, probe_idx};  // bit 31 = not found
        end
    end

endmodule

`default_nettype wire

/* mmu.sv */
`default_nettype none

module mmu #(
    parameter  bit ENABLE_TLB  = 1'b1,
    parameter  int TLB_ENTRIES = 16,
    localparam int IDX_W       = $clog2(TLB_ENTRIES)
) (
    input  logic                       clk,
    input  logic                       arst_n_i,

    input  logic                       user_mode_i,
    input  logic                       kseg0_uncached_i,
    input  logic [tlb_pkg::ASID_W-1:0] asid_i,

    input  logic [31:0]                inst_addr_i,
    input  logic                       inst_en_i,
    output logic [31:0]                inst_addr_o,
    output logic                       inst_uncached_o,
    output logic                       inst_except_miss_o,
    output logic                       inst_except_invalid_o,
    output logic                       inst_except_user_o,

    input  logic [31:0]                data_addr_i,
    input  logic                       data_en_i,
    input  logic                       data_we_i,
    output logic [31:0]                data_addr_o,
    output logic                       data_uncached_o,
    output logic                       data_except_miss_o,
    output logic                       data_except_invalid_o,
    output logic                       data_except_user_o,
    output logic                       data_except_modified_o,

    input  logic                       tlb_we_i,
    input  logic [IDX_W-1:0]           tlb_index_i,
    input  logic [tlb_pkg::VPN2_W-1:0] entry_vpn2_i,
    input  logic [tlb_pkg::ASID_W-1:0] entry_asid_i,
    input  logic                       entry_g_i,
    input  logic [tlb_pkg::PFN_W-1:0]  lo0_pfn_i,
    input  logic [tlb_pkg::CFLD_W-1:0] lo0_c_i,
    input  logic                       lo0_d_i,
    input  logic                       lo0_v_i,
    input  logic [tlb_pkg::PFN_W-1:0]  lo1_pfn_i,
    input  logic [tlb_pkg::CFLD_W-1:0] lo1_c_i,
    input  logic                       lo1_d_i,
    input  logic                       lo1_v_i,

    input  logic                       tlb_probe_i,
    output logic [31:0]                tlb_probe_res_o
);

    logic [31:0] inst_addr_map;
    logic [31:0] inst_addr_tlb;
    logic        inst_uncached_map;
    logic        inst_uncached_tlb;
    logic        inst_use_tlb;
    logic        inst_miss;
    logic        inst_valid;

    logic [31:0] data_addr_map;
    logic [31:0] data_addr_tlb;
    logic        data_uncached_map;
    logic        data_uncached_tlb;
    logic        data_use_tlb;
    logic        data_miss;
    logic        data_valid;
    logic        data_dirty;

    memory_map #(
        .ENABLE_TLB(ENABLE_TLB)
    ) u_map_inst (
        .addr_i          (inst_addr_i),
        .en_i            (inst_en_i),
        .user_mode_i     (user_mode_i),
        .kseg0_uncached_i(kseg0_uncached_i),
        .addr_o          (inst_addr_map),
        .uncached_o      (inst_uncached_map),
        .use_tlb_o       (inst_use_tlb),
        .except_user_o   (inst_except_user_o)
    );

    memory_map #(
        .ENABLE_TLB(ENABLE_TLB)
    ) u_map_data (
        .addr_i          (data_addr_i),
        .en_i            (data_en_i),
        .user_mode_i     (user_mode_i),
        .kseg0_uncached_i(kseg0_uncached_i),
        .addr_o          (data_addr_map),
        .uncached_o      (data_uncached_map),
        .use_tlb_o       (data_use_tlb),
        .except_user_o   (data_except_user_o)
    );

    generate
        if (ENABLE_TLB) begin : g_tlb
            tlb #(
                .TLB_ENTRIES(TLB_ENTRIES)
            ) u_tlb (
                .clk            (clk),
                .arst_n_i       (arst_n_i),
                .asid_i         (asid_i),
                .inst_addr_i    (inst_addr_i),
                .inst_addr_o    (inst_addr_tlb),
                .inst_uncached_o(inst_uncached_tlb),
                .inst_miss_o    (inst_miss),
                .inst_valid_o   (inst_valid),
                .data_addr_i    (data_addr_i),
                .data_addr_o    (data_addr_tlb),
                .data_uncached_o(data_uncached_tlb),
                .data_miss_o    (data_miss),
                .data_valid_o   (data_valid),
                .data_dirty_o   (data_dirty),
                .tlb_we_i       (tlb_we_i),
                .tlb_index_i    (tlb_index_i),
                .entry_vpn2_i   (entry_vpn2_i),
                .entry_asid_i   (entry_asid_i),
                .entry_g_i      (entry_g_i),
                .lo0_pfn_i      (lo0_pfn_i),
                .lo0_c_i        (lo0_c_i),
                .lo0_d_i        (lo0_d_i),
                .lo0_v_i        (lo0_v_i),
                .lo1_pfn_i      (lo1_pfn_i),
                .lo1_c_i        (lo1_c_i),
                .lo1_d_i        (lo1_d_i),
                .lo1_v_i        (lo1_v_i),
                .tlb_probe_i    (tlb_probe_i),
                .tlb_probe_res_o(tlb_probe_res_o)
            );
        end else begin : g_no_tlb
            assign inst_addr_tlb     = inst_addr_i;  // passthrough
            assign inst_uncached_tlb = 1'b0;
            assign inst_miss         = 1'b0;
            assign inst_valid        = 1'b1;
            assign data_addr_tlb     = data_addr_i;
            assign data_uncached_tlb = 1'b0;
            assign data_miss         = 1'b0;
            assign data_valid        = 1'b1;
            assign data_dirty        = 1'b0;
            assign tlb_probe_res_o   = 32'h8000_0000;  // never found
        end
    endgenerate

    assign inst_addr_o     = inst_use_tlb ? inst_addr_tlb : inst_addr_map;
    assign inst_uncached_o = inst_use_tlb ? inst_uncached_tlb : inst_uncached_map;
    assign data_addr_o     = data_use_tlb ? data_addr_tlb : data_addr_map;
    assign data_uncached_o = data_use_tlb ? data_uncached_tlb : data_uncached_map;

    assign inst_except_miss_o    = inst_en_i & inst_use_tlb & inst_miss;
    assign inst_except_invalid_o = inst_en_i & inst_use_tlb & ~inst_miss & ~inst_valid;

    assign data_except_miss_o    = data_en_i & data_use_tlb & data_miss;
    assign data_except_invalid_o = data_en_i & data_use_tlb & ~data_miss & ~data_valid;
    // store to a clean page
    assign data_except_modified_o = data_en_i & data_use_tlb & ~data_miss & data_valid
                                  & data_we_i & ~data_dirty;

endmodule

`default_nettype wire

/* mmu_props.sv */
`default_nettype none

module mmu_props (
    input logic        clk,
    input logic        arst_n_i,
    input logic        inst_en_i,
    input logic        data_en_i,
    input logic [31:0] inst_addr_i,
    input logic [31:0] data_addr_i,
    input logic        inst_miss_i,
    input logic        inst_invalid_i,
    input logic        inst_user_i,
    input logic        inst_uncached_i,
    input logic        data_miss_i,
    input logic        data_invalid_i,
    input logic        data_user_i,
    input logic        data_modified_i,
    input logic        data_uncached_i,
    input logic [31:0] probe_res_i
);
    timeunit 1ns;
    timeprecision 1ps;

    import mmu_pkg::*;

    int err_count = 0;

    a_inst_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
        !inst_en_i |-> !(inst_miss_i || inst_invalid_i || inst_user_i))
        else begin
            $error("inst exception raised while inst_en_i is low");
            err_count++;
        end

    a_data_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
        !data_en_i |-> !(data_miss_i || data_invalid_i || data_user_i || data_modified_i))
        else begin
            $error("data exception raised while data_en_i is low");
            err_count++;
        end

    a_inst_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(inst_miss_i && inst_invalid_i))
        else begin
            $error("inst miss and invalid raised together");
            err_count++;
        end

    a_data_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(data_miss_i && data_invalid_i))
        else begin
            $error("data miss and invalid raised together");
            err_count++;
        end

    a_inst_kseg1: assert property (@(posedge clk) disable iff (!arst_n_i)
        (inst_addr_i[31:29] == KSEG1_BASE[31:29]) |-> inst_uncached_i)
        else begin
            $error("inst kseg1 access reported cached");
            err_count++;
        end

    a_data_kseg1: assert property (@(posedge clk) disable iff (!arst_n_i)
        (data_addr_i[31:29] == KSEG1_BASE[31:29]) |-> data_uncached_i)
        else begin
            $error("data kseg1 access reported cached");
            err_count++;
        end

    // first cycle out of reset
    a_probe_reset: assert property (@(posedge clk)
        $rose(arst_n_i) |-> (probe_res_i == 32'h8000_0000))
        else begin
            $error("probe result not at its reset value after reset release");
            err_count++;
        end

endmodule

bind mmu mmu_props u_props (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .inst_en_i      (inst_en_i),
    .data_en_i      (data_en_i),
    .inst_addr_i    (inst_addr_i),
    .data_addr_i    (data_addr_i),
    .inst_miss_i    (inst_except_miss_o),
    .inst_invalid_i (inst_except_invalid_o),
    .inst_user_i    (inst_except_user_o),
    .inst_uncached_i(inst_uncached_o),
    .data_miss_i    (data_except_miss_o),
    .data_invalid_i (data_except_invalid_o),
    .data_user_i    (data_except_user_o),
    .data_modified_i(data_except_modified_o),
    .data_uncached_i(data_uncached_o),
    .probe_res_i    (tlb_probe_res_o)
);

`default_nettype wire

/* tb_mmu.sv */
`default_nettype none

module tb_mmu;
    timeunit 1ns;
    timeprecision 1ps;

    import mmu_pkg::*;
    import tlb_pkg::*;

    localparam int ENTRIES       = 16;
    localparam int PROBE_TIMEOUT = 8;

    typedef struct packed {
        logic [31:0] addr;
        logic        unc;
        logic        miss;
        logic        inval;
        logic        user;
        logic        modif;
    } xlate_t;

    logic                clk;
    logic                arst_n_i;
    logic                user_mode_i;
    logic                kseg0_uncached_i;
    logic [ASID_W-1:0]   asid_i;
    logic [31:0]         inst_addr_i;
    logic                inst_en_i;
    logic [31:0]         inst_addr_o;
    logic                inst_uncached_o;
    logic                inst_except_miss_o;
    logic                inst_except_invalid_o;
    logic                inst_except_user_o;
    logic [31:0]         data_addr_i;
    logic                data_en_i;
    logic                data_we_i;
    logic [31:0]         data_addr_o;
    logic                data_uncached_o;
    logic                data_except_miss_o;
    logic                data_except_invalid_o;
    logic                data_except_user_o;
    logic                data_except_modified_o;
    logic                tlb_we_i;
    logic [3:0]          tlb_index_i;
    logic [VPN2_W-1:0]   entry_vpn2_i;
    logic [ASID_W-1:0]   entry_asid_i;
    logic                entry_g_i;
    logic [PFN_W-1:0]    lo0_pfn_i;
    logic [CFLD_W-1:0]   lo0_c_i;
    logic                lo0_d_i;
    logic                lo0_v_i;
    logic [PFN_W-1:0]    lo1_pfn_i;
    logic [CFLD_W-1:0]   lo1_c_i;
    logic                lo1_d_i;
    logic                lo1_v_i;
    logic                tlb_probe_i;
    logic [31:0]         tlb_probe_res_o;

    logic [31:0]         lfsr_q;
    tlb_entry_t          shadow [ENTRIES];
    logic [ENTRIES-1:0]  written;
    logic                chk_en;
    string               test_name;
    int                  n_pass;
    int                  n_fail;
    int                  n_tests;
    int                  fail_base;
    xlate_t              exp_i;
    xlate_t              exp_d;

    mmu #(
        .ENABLE_TLB (1'b1),
        .TLB_ENTRIES(ENTRIES)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // small pool so lookups hit often
    function automatic logic [VPN2_W-1:0] pool_vpn2();
        logic [2:0] top;
        top = (take_bits(1) != 0) ? 3'b110 : 3'b001;
        return {top, 12'h000, 4'(take_bits(4))};
    endfunction

    function automatic tlb_entry_t random_entry();
        tlb_entry_t e;
        e.vpn2 = pool_vpn2();
        e.asid = ASID_W'(take_bits(2));
        e.g    = (take_bits(3) == 0);
        e.pfn0 = PFN_W'(take_bits(PFN_W));
        e.c0   = CFLD_W'(take_bits(CFLD_W));
        e.d0   = 1'(take_bits(1));
        e.v0   = 1'(take_bits(1));
        e.pfn1 = PFN_W'(take_bits(PFN_W));
        e.c1   = CFLD_W'(take_bits(CFLD_W));
        e.d1   = 1'(take_bits(1));
        e.v1   = 1'(take_bits(1));
        return e;
    endfunction

    function automatic logic [31:0] mapped_addr();
        logic [VPN2_W-1:0] vpn;
        if (take_bits(1) != 0) begin
            vpn = shadow[4'(take_bits(4))].vpn2;  // reuse a written pair
        end else begin
            vpn = pool_vpn2();
        end
        return {vpn, 13'(take_bits(13))};
    endfunction

    function automatic logic entry_matches(input int i, input logic [VPN2_W-1:0] vpn2,
                                           input logic [ASID_W-1:0] asid);
        return written[i] && (shadow[i].vpn2 == vpn2) && (shadow[i].g || shadow[i].asid == asid);
    endfunction

    function automatic xlate_t ref_translate(input logic [31:0] va, input logic en,
                                             input logic we, input logic is_data,
                                             input logic user, input logic k0_unc,
                                             input logic [ASID_W-1:0] asid);
        xlate_t            r;
        logic              hit;
        tlb_entry_t        e;
        logic [PFN_W-1:0]  pfn;
        logic [CFLD_W-1:0] c;
        logic              d;
        logic              v;
        r      = '0;
        r.addr = va;
        r.user = en & user & va[31];
        hit    = 1'b0;
        e      = '0;
        if (va[31:29] == KSEG0_BASE[31:29]) begin
            r.addr = {3'b000, va[28:0]};
            r.unc  = k0_unc;
        end else if (va[31:29] == KSEG1_BASE[31:29]) begin
            r.addr = {3'b000, va[28:0]};
            r.unc  = 1'b1;
        end else begin
            for (int i = ENTRIES - 1; i >= 0; i--) begin  // lowest index wins
                if (entry_matches(i, va[31:13], asid)) begin
                    hit = 1'b1;
                    e   = shadow[i];
                end
            end
            pfn = va[12] ? e.pfn1 : e.pfn0;
            c   = va[12] ? e.c1 : e.c0;
            d   = va[12] ? e.d1 : e.d0;
            v   = va[12] ? e.v1 : e.v0;
            if (!hit) begin
                r.miss = en;  // va goes out unchanged
            end else begin
                r.addr  = {pfn, va[11:0]};
                r.unc   = (c == CACHE_UNCACHED);
                r.inval = en & ~v;
                r.modif = en & is_data & v & we & ~d;
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] ref_probe(input logic [VPN2_W-1:0] vpn2,
                                              input logic [ASID_W-1:0] asid);
        logic [31:0] r;
        r = 32'h8000_0000;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (entry_matches(i, vpn2, asid)) begin
                r = 32'(i);
            end
        end
        return r;
    endfunction

    task automatic compare_field(input string field, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (exp === got) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("** Error %s %s: expected %h, actual %h", test_name, field, exp, got);
        end
    endtask

    always @(negedge clk) begin
        if (chk_en) begin
            exp_i = ref_translate(inst_addr_i, inst_en_i, 1'b0, 1'b0, user_mode_i,
                                  kseg0_uncached_i, asid_i);
            exp_d = ref_translate(data_addr_i, data_en_i, data_we_i, 1'b1, user_mode_i,
                                  kseg0_uncached_i, asid_i);
            compare_field("inst_addr", exp_i.addr, inst_addr_o);
            compare_field("inst_uncached", exp_i.unc, inst_uncached_o);
            compare_field("inst_miss", exp_i.miss, inst_except_miss_o);
            compare_field("inst_invalid", exp_i.inval, inst_except_invalid_o);
            compare_field("inst_user", exp_i.user, inst_except_user_o);
            compare_field("data_addr", exp_d.addr, data_addr_o);
            compare_field("data_uncached", exp_d.unc, data_uncached_o);
            compare_field("data_miss", exp_d.miss, data_except_miss_o);
            compare_field("data_invalid", exp_d.inval, data_except_invalid_o);
            compare_field("data_user", exp_d.user, data_except_user_o);
            compare_field("data_modified", exp_d.modif, data_except_modified_o);
        end
    end

    task automatic drive_lookup(input logic [31:0] ia, input logic [31:0] da, input logic en,
                                input logic we, input logic user, input logic k0_unc,
                                input logic [ASID_W-1:0] asid);
        @(posedge clk);
        inst_addr_i      <= ia;
        inst_en_i        <= en;
        data_addr_i      <= da;
        data_en_i        <= en;
        data_we_i        <= we;
        user_mode_i      <= user;
        kseg0_uncached_i <= k0_unc;
        asid_i           <= asid;
        tlb_we_i         <= 1'b0;
        tlb_probe_i      <= 1'b0;
        chk_en           <= 1'b1;
    endtask

    task automatic write_entry(input logic [3:0] idx, input tlb_entry_t e);
        @(posedge clk);
        tlb_we_i     <= 1'b1;
        tlb_index_i  <= idx;
        entry_vpn2_i <= e.vpn2;
        entry_asid_i <= e.asid;
        entry_g_i    <= e.g;
        lo0_pfn_i    <= e.pfn0;
        lo0_c_i      <= e.c0;
        lo0_d_i      <= e.d0;
        lo0_v_i      <= e.v0;
        lo1_pfn_i    <= e.pfn1;
        lo1_c_i      <= e.c1;
        lo1_d_i      <= e.d1;
        lo1_v_i      <= e.v1;
        tlb_probe_i  <= 1'b0;
        chk_en       <= 1'b0;
        shadow[idx]  = e;
        written[idx] = 1'b1;
    endtask

    task automatic probe_pair(input logic [VPN2_W-1:0] vpn2, input logic [ASID_W-1:0] asid);
        logic [31:0] exp;
        logic        timed_out;
        int          n;
        exp = ref_probe(vpn2, asid);
        @(posedge clk);
        entry_vpn2_i <= vpn2;
        entry_asid_i <= asid;
        tlb_probe_i  <= 1'b1;
        tlb_we_i     <= 1'b0;
        chk_en       <= 1'b0;
        @(posedge clk);  // probe sampled here
        tlb_probe_i  <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (tlb_probe_res_o !== exp && n < PROBE_TIMEOUT);
        timed_out = (tlb_probe_res_o !== exp);
        if (timed_out) begin
            $display("probe of vpn2 %h asid %h did not return the expected result in %0d cycles",
                     vpn2, asid, PROBE_TIMEOUT);
        end
        compare_field("probe_res", exp, tlb_probe_res_o);
        if (!timed_out) begin
            assert (n == 1) begin
                n_pass++;
            end else begin
                n_fail++;
                $display("probe result of %s arrived after %0d cycles instead of one",
                         test_name, n);
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        fail_base = n_fail;
    endtask

    task automatic finish_test();
        @(posedge clk);
        chk_en      <= 1'b0;
        tlb_we_i    <= 1'b0;
        tlb_probe_i <= 1'b0;
        inst_en_i   <= 1'b0;
        data_en_i   <= 1'b0;
        n_tests++;
        $display("%s finished, %0d errors", test_name, n_fail - fail_base);
    endtask

    initial begin
        logic [31:0] ia;
        logic [31:0] da;
        logic [3:0]  sel;
        tlb_entry_t  pe;
        lfsr_q  = 32'h01643fa8;
        written = '0;
        n_pass  = 0;
        n_fail  = 0;
        n_tests = 0;
        chk_en  = 1'b0;
        arst_n_i = 1'b0;
        {user_mode_i, kseg0_uncached_i, asid_i} = '0;
        {inst_addr_i, inst_en_i, data_addr_i, data_en_i, data_we_i} = '0;
        {tlb_we_i, tlb_index_i, entry_vpn2_i, entry_asid_i, entry_g_i} = '0;
        {lo0_pfn_i, lo0_c_i, lo0_d_i, lo0_v_i} = '0;
        {lo1_pfn_i, lo1_c_i, lo1_d_i, lo1_v_i} = '0;
        tlb_probe_i = 1'b0;
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;

        start_test("empty_tlb");
        for (int k = 0; k < 20; k++) begin
            ia = {1'b0, 31'(take_bits(31))};
            da = {KSEG2_BASE[31:29], 29'(take_bits(29))};
            drive_lookup(k[0] ? da : ia, k[0] ? ia : da, k < 16, 1'(take_bits(1)), 1'b0,
                         1'b0, ASID_W'(take_bits(8)));
        end
        finish_test();

        start_test("unmapped");
        for (int k = 0; k < 24; k++) begin
            ia = {KSEG0_BASE[31:29], 29'(take_bits(29))};
            da = {KSEG1_BASE[31:29], 29'(take_bits(29))};
            drive_lookup(k[1] ? da : ia, k[1] ? ia : da, 1'b1, 1'(take_bits(1)), 1'b0,
                         k[0], 8'h00);  // kseg0 cacheability toggles
        end
        finish_test();

        start_test("user_mode");
        for (int k = 0; k < 24; k++) begin
            ia = take_bits(32);
            da = take_bits(32);
            drive_lookup(ia, da, 1'b1, 1'(take_bits(1)), 1'b1, 1'b0, ASID_W'(take_bits(8)));
        end
        finish_test();

        start_test("mapped");
        for (int k = 0; k < ENTRIES; k++) begin
            write_entry(4'(k), random_entry());
        end
        for (int k = 0; k < 80; k++) begin
            ia = mapped_addr();
            da = mapped_addr();
            drive_lookup(ia, da, 1'b1, 1'(take_bits(1)), 1'b0, 1'b0, ASID_W'(take_bits(2)));
        end
        finish_test();

        start_test("store_protect");
        pe      = '0;
        pe.vpn2 = {3'b010, 16'h1234};
        pe.asid = 8'h3c;
        pe.g    = 1'b1;
        pe.pfn0 = 20'h0badc;
        pe.c0   = 3'd3;
        pe.v0   = 1'b1;  // clean even page
        pe.pfn1 = 20'h0cafe;
        pe.c1   = CACHE_UNCACHED;
        pe.d1   = 1'b1;
        pe.v1   = 1'b1;
        write_entry(4'd0, pe);
        for (int k = 0; k < 8; k++) begin
            ia = {pe.vpn2, 1'b0, 12'(take_bits(12))};
            da = {pe.vpn2, 1'b1, 12'(take_bits(12))};
            drive_lookup(ia, ia, 1'b1, 1'b1, 1'b0, 1'b0, 8'h01);
            drive_lookup(ia, ia, 1'b1, 1'b0, 1'b0, 1'b0, 8'h02);
            drive_lookup(da, da, 1'b1, 1'b1, 1'b0, 1'b0, 8'h03);
        end
        finish_test();

        start_test("probe");
        for (int k = 0; k < 6; k++) begin
            sel = 4'(take_bits(4));
            probe_pair(shadow[sel].vpn2, shadow[sel].asid);
            probe_pair({KSEG0_BASE[31:29], 16'(take_bits(16))}, ASID_W'(take_bits(8)));
        end
        probe_pair(pe.vpn2, 8'h77);  // global entry matches any asid
        finish_test();

        $display("%0d tests, %0d checks ok, %0d checks failing, %0d assertion failures",
                 n_tests, n_pass, n_fail, DUT.u_props.err_count);
        if (n_fail == 0 && DUT.u_props.err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
mmu_pkg.sv
tlb_pkg.sv
memory_map.sv
tlb.sv
mmu.sv
mmu_props.sv
tb_mmu.sv

/* Bender.yml */
package:
  name: mmu

sources:
  - mmu_pkg.sv
  - tlb_pkg.sv
  - memory_map.sv
  - tlb.sv
  - mmu.sv
  - target: test
    files:
      - mmu_props.sv
      - tb_mmu.sv
